// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fwd_tb
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG) || { echo "No result line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
common/fwd_pkg.sv
hdl/pkt_loader.sv
pkt_buf/pkt_buf.sv
fwd_arb/ready_tree.sv
fwd_arb/fwd_arb.sv
hdl/forwarder.sv
hdl/fwd_top.sv
tests/fwd_sva.sv
tests/fwd_tb.sv

// ==== common/fwd_pkg.sv ====
package fwd_pkg;

   // Buffer count and index width
   localparam int num_bufs = 4;
   localparam int sel_w = 2;

   // Packet word and buffer geometry
   localparam int data_w = 32;
   localparam int addr_w = 4;
   localparam int max_words = 16;

   // One extra bit so a full 16-word packet fits
   localparam int len_w = 5;

   // Life cycle of one packet buffer
   typedef enum logic [1:0] {
      BUF_EMPTY,
      BUF_FILLING,
      BUF_READY,
      BUF_LOCKED
   } buf_state_t;

   // Forwarder sequence
   typedef enum logic [1:0] {
      FWD_IDLE,
      FWD_WAIT_LEN,
      FWD_READ,
      FWD_DRAIN
   } fwd_state_t;

endpackage

// ==== fwd_arb/fwd_arb.sv ====
`timescale 1ns/1ps

module fwd_arb (
   input  logic                                              clk,
   input  logic                                              rst,
   // Forwarder side
   input  logic [fwd_pkg::addr_w-1:0]                        addr,
   input  logic                                              rd_en,
   output logic [fwd_pkg::data_w-1:0]                        rd_data,
   output logic                                              rd_data_vld,
   output logic [fwd_pkg::len_w-1:0]                         byte_len,
   input  logic                                              done,
   output logic                                              rdy,
   input  logic                                              ack,
   // Buffer side
   output logic [fwd_pkg::addr_w-1:0]                        fwd_addr,
   output logic [fwd_pkg::num_bufs-1:0]                      fwd_rd_en,
   input  logic [fwd_pkg::num_bufs-1:0][fwd_pkg::data_w-1:0] fwd_rd_data,
   input  logic [fwd_pkg::num_bufs-1:0]                      fwd_rd_data_vld,
   input  logic [fwd_pkg::num_bufs-1:0][fwd_pkg::len_w-1:0]  fwd_byte_len,
   output logic [fwd_pkg::num_bufs-1:0]                      fwd_done,
   input  logic [fwd_pkg::num_bufs-1:0]                      rdy_for_fwd,
   output logic [fwd_pkg::num_bufs-1:0]                      rdy_for_fwd_ack
);

   logic [fwd_pkg::sel_w-1:0] sel_next;
   logic [fwd_pkg::sel_w-1:0] sel_q;

   // Handshake and the choice of the next buffer
   ready_tree u_tree (
      .clk     (clk),
      .rst     (rst),
      .rdy_in  (rdy_for_fwd),
      .ack     (ack),
      .rdy     (rdy),
      .ack_out (rdy_for_fwd_ack),
      .tag     (sel_next)
   );

   // Selection held from one handshake to the next
   always_ff @(posedge clk) begin
      if (rst)
         sel_q <= '0;
      else if (rdy && ack)
         sel_q <= sel_next;
   end

   // Single register stage on the way back to the forwarder
   always_ff @(posedge clk) begin
      rd_data <= fwd_rd_data[sel_q];
      byte_len <= fwd_byte_len[sel_q];
   end

   always_ff @(posedge clk) begin
      if (rst)
         rd_data_vld <= 1'b0;
      else
         rd_data_vld <= fwd_rd_data_vld[sel_q];
   end

   // Address and read enable go to every buffer
   assign fwd_addr = addr;
   assign fwd_rd_en = {fwd_pkg::num_bufs{rd_en}};

   // Done frees only the selected buffer
   always_comb begin
      for (int i = 0; i < fwd_pkg::num_bufs; i++)
         fwd_done[i] = done && (sel_q == fwd_pkg::sel_w'(i));
   end

endmodule

// ==== fwd_arb/ready_tree.sv ====
`timescale 1ns/1ps

module ready_tree (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [fwd_pkg::num_bufs-1:0]  rdy_in,
   input  logic                          ack,
   output logic                          rdy,
   output logic [fwd_pkg::num_bufs-1:0]  ack_out,
   output logic [fwd_pkg::sel_w-1:0]     tag
);

   logic [fwd_pkg::sel_w-1:0]    last_q;
   logic [fwd_pkg::num_bufs-1:0] rot;
   logic                         hit_lo;
   logic                         hit_hi;
   logic [fwd_pkg::sel_w-1:0]    idx_lo;
   logic [fwd_pkg::sel_w-1:0]    idx_hi;
   logic [fwd_pkg::sel_w-1:0]    win_rot;

   // Rotate so that position 0 is the buffer just after the last one served
   always_comb begin
      for (int k = 0; k < fwd_pkg::num_bufs; k++)
         rot[k] = rdy_in[last_q + fwd_pkg::sel_w'(k + 1)];
   end

   // First level, two pairs
   assign hit_lo = rot[0] || rot[1];
   assign idx_lo = rot[0] ? 2'd0 : 2'd1;
   assign hit_hi = rot[2] || rot[3];
   assign idx_hi = rot[2] ? 2'd2 : 2'd3;

   // Second level, lower pair wins
   assign rdy = hit_lo || hit_hi;
   assign win_rot = hit_lo ? idx_lo : idx_hi;

   // Undo the rotation, wraps in sel_w bits
   assign tag = last_q + win_rot + 1'b1;

   // Acknowledge goes to the winner only
   always_comb begin
      for (int i = 0; i < fwd_pkg::num_bufs; i++)
         ack_out[i] = ack && rdy && (tag == fwd_pkg::sel_w'(i));
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         // First search starts at buffer 0
         last_q <= fwd_pkg::sel_w'(fwd_pkg::num_bufs - 1);
      end else if (rdy && ack) begin
         last_q <= tag;
      end
   end

endmodule

// ==== hdl/forwarder.sv ====
`timescale 1ns/1ps

module forwarder (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        rdy,
   output logic                        ack,
   output logic [fwd_pkg::addr_w-1:0]  addr,
   output logic                        rd_en,
   input  logic [fwd_pkg::data_w-1:0]  rd_data,
   input  logic                        rd_data_vld,
   input  logic [fwd_pkg::len_w-1:0]   byte_len,
   output logic                        done,
   output logic [fwd_pkg::data_w-1:0]  out_data,
   output logic                        out_vld,
   output logic                        out_last
);

   fwd_pkg::fwd_state_t        state_q;
   logic                       wait_q;
   logic [fwd_pkg::addr_w-1:0] issue_cnt;
   logic [fwd_pkg::addr_w-1:0] rcv_cnt;
   logic [fwd_pkg::len_w-1:0]  len_q;
   logic [fwd_pkg::len_w-1:0]  last_idx;

   assign last_idx = len_q - 1'b1;

   // Grab whatever is ready as soon as we are idle
   assign ack = (state_q == fwd_pkg::FWD_IDLE) && rdy;

   // One read per cycle while issuing
   assign rd_en = (state_q == fwd_pkg::FWD_READ);
   assign addr = issue_cnt;

   // Words pass straight through, no back-pressure
   assign out_data = rd_data;
   assign out_vld = rd_data_vld;
   assign out_last = rd_data_vld && ({1'b0, rcv_cnt} == last_idx);

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= fwd_pkg::FWD_IDLE;
         wait_q <= 1'b0;
         issue_cnt <= '0;
         rcv_cnt <= '0;
         done <= 1'b0;
      end else begin
         // Done in the cycle after the last word
         done <= out_last;
         if (rd_data_vld)
            rcv_cnt <= rcv_cnt + 1'b1;
         case (state_q)
            fwd_pkg::FWD_IDLE: begin
               if (rdy) begin
                  state_q <= fwd_pkg::FWD_WAIT_LEN;
                  wait_q <= 1'b0;
                  issue_cnt <= '0;
                  rcv_cnt <= '0;
               end
            end
            fwd_pkg::FWD_WAIT_LEN: begin
               // Selection then mux register, length valid on the second cycle
               wait_q <= 1'b1;
               if (wait_q) begin
                  len_q <= byte_len;
                  state_q <= fwd_pkg::FWD_READ;
               end
            end
            fwd_pkg::FWD_READ: begin
               issue_cnt <= issue_cnt + 1'b1;
               if ({1'b0, issue_cnt} == last_idx)
                  state_q <= fwd_pkg::FWD_DRAIN;
            end
            default: begin
               // Wait for the read pipeline to empty
               if (out_last)
                  state_q <= fwd_pkg::FWD_IDLE;
            end
         endcase
      end
   end

endmodule

// ==== hdl/fwd_top.sv ====
`timescale 1ns/1ps

module fwd_top (
   input  logic                        clk,
   input  logic                        rst,
   input  logic [fwd_pkg::data_w-1:0]  in_data,
   input  logic                        in_vld,
   input  logic                        in_last,
   output logic                        in_rdy,
   output logic [fwd_pkg::data_w-1:0]  out_data,
   output logic                        out_vld,
   output logic                        out_last
);

   // Loader to buffers
   logic [fwd_pkg::num_bufs-1:0]                      buf_empty;
   logic [fwd_pkg::num_bufs-1:0]                      wr_en;
   logic [fwd_pkg::addr_w-1:0]                        wr_addr;
   logic [fwd_pkg::data_w-1:0]                        wr_data;
   logic                                              wr_last;

   // Buffers to arbiter
   logic [fwd_pkg::addr_w-1:0]                        fwd_addr;
   logic [fwd_pkg::num_bufs-1:0]                      fwd_rd_en;
   logic [fwd_pkg::num_bufs-1:0][fwd_pkg::data_w-1:0] fwd_rd_data;
   logic [fwd_pkg::num_bufs-1:0]                      fwd_rd_data_vld;
   logic [fwd_pkg::num_bufs-1:0][fwd_pkg::len_w-1:0]  fwd_byte_len;
   logic [fwd_pkg::num_bufs-1:0]                      fwd_done;
   logic [fwd_pkg::num_bufs-1:0]                      rdy_for_fwd;
   logic [fwd_pkg::num_bufs-1:0]                      rdy_for_fwd_ack;

   // Arbiter to forwarder
   logic                                              rdy;
   logic                                              ack;
   logic [fwd_pkg::addr_w-1:0]                        addr;
   logic                                              rd_en;
   logic [fwd_pkg::data_w-1:0]                        rd_data;
   logic                                              rd_data_vld;
   logic [fwd_pkg::len_w-1:0]                         byte_len;
   logic                                              done;

   pkt_loader u_loader (
      .clk       (clk),
      .rst       (rst),
      .in_data   (in_data),
      .in_vld    (in_vld),
      .in_last   (in_last),
      .in_rdy    (in_rdy),
      .buf_empty (buf_empty),
      .wr_en     (wr_en),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .wr_last   (wr_last)
   );

   // Write bus shared, one enable bit each
   for (genvar i = 0; i < fwd_pkg::num_bufs; i++) begin : g_buf
      pkt_buf u_buf (
         .clk             (clk),
         .rst             (rst),
         .wr_en           (wr_en[i]),
         .wr_addr         (wr_addr),
         .wr_data         (wr_data),
         .wr_last         (wr_last),
         .empty           (buf_empty[i]),
         .rdy_for_fwd     (rdy_for_fwd[i]),
         .rdy_for_fwd_ack (rdy_for_fwd_ack[i]),
         .addr            (fwd_addr),
         .rd_en           (fwd_rd_en[i]),
         .rd_data         (fwd_rd_data[i]),
         .rd_data_vld     (fwd_rd_data_vld[i]),
         .byte_len        (fwd_byte_len[i]),
         .done            (fwd_done[i])
      );
   end

   fwd_arb u_arb (
      .clk             (clk),
      .rst             (rst),
      .addr            (addr),
      .rd_en           (rd_en),
      .rd_data         (rd_data),
      .rd_data_vld     (rd_data_vld),
      .byte_len        (byte_len),
      .done            (done),
      .rdy             (rdy),
      .ack             (ack),
      .fwd_addr        (fwd_addr),
      .fwd_rd_en       (fwd_rd_en),
      .fwd_rd_data     (fwd_rd_data),
      .fwd_rd_data_vld (fwd_rd_data_vld),
      .fwd_byte_len    (fwd_byte_len),
      .fwd_done        (fwd_done),
      .rdy_for_fwd     (rdy_for_fwd),
      .rdy_for_fwd_ack (rdy_for_fwd_ack)
   );

   forwarder u_fwd (
      .clk         (clk),
      .rst         (rst),
      .rdy         (rdy),
      .ack         (ack),
      .addr        (addr),
      .rd_en       (rd_en),
      .rd_data     (rd_data),
      .rd_data_vld (rd_data_vld),
      .byte_len    (byte_len),
      .done        (done),
      .out_data    (out_data),
      .out_vld     (out_vld),
      .out_last    (out_last)
   );

endmodule

// ==== hdl/pkt_loader.sv ====
`timescale 1ns/1ps

module pkt_loader (
   input  logic                                clk,
   input  logic                                rst,
   input  logic [fwd_pkg::data_w-1:0]          in_data,
   input  logic                                in_vld,
   input  logic                                in_last,
   output logic                                in_rdy,
   input  logic [fwd_pkg::num_bufs-1:0]        buf_empty,
   output logic [fwd_pkg::num_bufs-1:0]        wr_en,
   output logic [fwd_pkg::addr_w-1:0]          wr_addr,
   output logic [fwd_pkg::data_w-1:0]          wr_data,
   output logic                                wr_last
);

   logic                       up_q;
   logic                       busy_q;
   logic [fwd_pkg::sel_w-1:0]  tgt_q;
   logic [fwd_pkg::addr_w-1:0] cnt_q;
   logic [fwd_pkg::sel_w-1:0]  pick;
   logic [fwd_pkg::sel_w-1:0]  cur;
   logic                       take;

   // Lowest-index empty buffer, scanned from the top down
   always_comb begin
      pick = '0;
      for (int i = fwd_pkg::num_bufs - 1; i >= 0; i--) begin
         if (buf_empty[i])
            pick = fwd_pkg::sel_w'(i);
      end
   end

   // Between packets we need a free buffer, inside one we keep the target
   assign in_rdy = up_q && (busy_q || (|buf_empty));
   assign take = in_vld && in_rdy;
   assign cur = busy_q ? tgt_q : pick;

   // Write steering, one-hot towards the current target
   always_comb begin
      for (int i = 0; i < fwd_pkg::num_bufs; i++)
         wr_en[i] = take && (cur == fwd_pkg::sel_w'(i));
   end

   assign wr_addr = busy_q ? cnt_q : '0;
   assign wr_data = in_data;
   assign wr_last = in_last;

   always_ff @(posedge clk) begin
      if (rst) begin
         up_q <= 1'b0;
         busy_q <= 1'b0;
         tgt_q <= '0;
         cnt_q <= '0;
      end else begin
         // Hold in_rdy low for one cycle out of reset
         up_q <= 1'b1;
         if (take) begin
            if (in_last) begin
               busy_q <= 1'b0;
               cnt_q <= '0;
            end else begin
               busy_q <= 1'b1;
               tgt_q <= cur;
               cnt_q <= cnt_q + 1'b1;
            end
         end
      end
   end

endmodule

// ==== pkt_buf/pkt_buf.sv ====
`timescale 1ns/1ps

module pkt_buf (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        wr_en,
   input  logic [fwd_pkg::addr_w-1:0]  wr_addr,
   input  logic [fwd_pkg::data_w-1:0]  wr_data,
   input  logic                        wr_last,
   output logic                        empty,
   output logic                        rdy_for_fwd,
   input  logic                        rdy_for_fwd_ack,
   input  logic [fwd_pkg::addr_w-1:0]  addr,
   input  logic                        rd_en,
   output logic [fwd_pkg::data_w-1:0]  rd_data,
   output logic                        rd_data_vld,
   output logic [fwd_pkg::len_w-1:0]   byte_len,
   input  logic                        done
);

   logic [fwd_pkg::data_w-1:0] mem [fwd_pkg::max_words];
   logic [fwd_pkg::len_w-1:0]  len_q;
   fwd_pkg::buf_state_t        state_q;
   logic                       rd_ok;

   assign empty = (state_q == fwd_pkg::BUF_EMPTY);
   assign rdy_for_fwd = (state_q == fwd_pkg::BUF_READY);
   assign byte_len = len_q;

   // Reads are shared by all buffers, only the locked one answers
   assign rd_ok = rd_en && (state_q == fwd_pkg::BUF_LOCKED);

   // Storage and the length of the stored packet
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
         if (wr_last)
            len_q <= {1'b0, wr_addr} + 1'b1;
      end
      if (rd_ok)
         rd_data <= mem[addr];
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= fwd_pkg::BUF_EMPTY;
         rd_data_vld <= 1'b0;
      end else begin
         rd_data_vld <= rd_ok;
         case (state_q)
            fwd_pkg::BUF_EMPTY, fwd_pkg::BUF_FILLING: begin
               if (wr_en)
                  state_q <= wr_last ? fwd_pkg::BUF_READY : fwd_pkg::BUF_FILLING;
            end
            fwd_pkg::BUF_READY: begin
               // Granted by the arbiter
               if (rdy_for_fwd_ack)
                  state_q <= fwd_pkg::BUF_LOCKED;
            end
            default: begin
               if (done)
                  state_q <= fwd_pkg::BUF_EMPTY;
            end
         endcase
      end
   end

endmodule

// ==== tests/fwd_sva.sv ====
`timescale 1ns/1ps

module fwd_sva (
   input logic                         clk,
   input logic                         rst,
   input logic [fwd_pkg::num_bufs-1:0] rdy_for_fwd,
   input logic [fwd_pkg::num_bufs-1:0] rdy_for_fwd_ack,
   input logic [fwd_pkg::num_bufs-1:0] fwd_done
);

   int fail_cnt = 0;

   // One grant at a time
   a_ack_onehot: assert property (@(posedge clk) disable iff (rst)
      $onehot0(rdy_for_fwd_ack))
      else begin
         fail_cnt++;
         $error("rdy_for_fwd_ack has more than one bit set");
      end

   // Grant only to a buffer in BUF_READY
   a_ack_to_ready: assert property (@(posedge clk) disable iff (rst)
      (rdy_for_fwd_ack & ~rdy_for_fwd) == '0)
      else begin
         fail_cnt++;
         $error("rdy_for_fwd_ack sent to a buffer that is not ready");
      end

   // A granted buffer leaves BUF_READY on the next cycle
   a_ack_leaves_ready: assert property (@(posedge clk) disable iff (rst)
      (|rdy_for_fwd_ack) |=> ((rdy_for_fwd & $past(rdy_for_fwd_ack)) == '0))
      else begin
         fail_cnt++;
         $error("granted buffer still ready one cycle after rdy_for_fwd_ack");
      end

   // Done frees a single buffer and never one still waiting for a grant
   a_done_onehot: assert property (@(posedge clk) disable iff (rst)
      $onehot0(fwd_done) && ((fwd_done & rdy_for_fwd) == '0))
      else begin
         fail_cnt++;
         $error("fwd_done has more than one bit set or frees a ready buffer");
      end

endmodule

bind fwd_arb fwd_sva u_sva (
   .clk             (clk),
   .rst             (rst),
   .rdy_for_fwd     (rdy_for_fwd),
   .rdy_for_fwd_ack (rdy_for_fwd_ack),
   .fwd_done        (fwd_done)
);

// ==== tests/fwd_tb.sv ====
`timescale 1ns/1ps

module fwd_tb;

   localparam int num_pkts = 200;
   localparam int pkt_cycles = 40;
   localparam int cycle_limit = num_pkts * pkt_cycles;
   localparam int nb = fwd_pkg::num_bufs;

   logic                       clk;
   logic                       rst;
   logic [fwd_pkg::data_w-1:0] in_data;
   logic                       in_vld;
   logic                       in_last;
   logic                       in_rdy;
   logic [fwd_pkg::data_w-1:0] out_data;
   logic                       out_vld;
   logic                       out_last;

   // Reference model, indexed by sequence number
   logic [fwd_pkg::data_w-1:0] sent [num_pkts][fwd_pkg::max_words];
   int                         sent_len [num_pkts];
   bit                         pending [num_pkts];
   int                         buf_of [num_pkts];
   bit [nb-1:0]                used;
   bit [nb-1:0]                ready_m;
   bit [nb-1:0]                ready_hist [8];
   int                         held, max_held, n_pending, last_served;
   bit                         mid, take_last, take_mid;
   int                         take_buf;
   bit                         rel1_v, rel2_v;
   int                         rel1_buf, rel2_buf;
   bit                         out_busy;
   int                         out_seq, out_idx;

   // Stimulus state
   logic [31:0]                lfsr = 32'hd759;
   bit                         active, gaps_on, will_take, rdy_chk;
   int                         cur, wcur, gap, next_seq, phase_end;
   int                         cyc, cycle_cnt, errors, checks;

   fwd_top uut (
      .clk      (clk),
      .rst      (rst),
      .in_data  (in_data),
      .in_vld   (in_vld),
      .in_last  (in_last),
      .in_rdy   (in_rdy),
      .out_data (out_data),
      .out_vld  (out_vld),
      .out_last (out_last)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Hard stop sized for the whole packet count
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < cycle_limit) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout after %0d cycles, packets still in flight: %0d", cycle_limit, n_pending);
      $display("Simulation failed");
      $finish;
   end

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // Next ready buffer after the last one served
   function automatic int pick_after(input bit [nb-1:0] rdy_set, input int last);
      for (int k = 1; k <= nb; k++) begin
         if (rdy_set[(last + k) % nb])
            return (last + k) % nb;
      end
      return -1;
   endfunction

   task automatic log_mismatch(input string msg);
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      errors++;
   endtask

   task automatic monitor_step();
      int seq;
      int pred;
      cyc++;
      // Word taken at the last rising edge
      if (take_last) begin
         held++;
         ready_m[take_buf] = 1'b1;
         mid = 1'b0;
      end
      if (take_mid)
         mid = 1'b1;
      if (held > max_held)
         max_held = held;
      // Buffer is empty again two cycles after out_last
      if (rel2_v) begin
         held--;
         used[rel2_buf] = 1'b0;
      end
      rel2_v = rel1_v;
      rel2_buf = rel1_buf;
      rel1_v = 1'b0;
      if (rdy_chk) begin
         checks++;
         if (in_rdy !== (mid || held < nb))
            log_mismatch($sformatf("in_rdy=%0b with %0d packets held", in_rdy, held));
      end
      // First word carries the sequence number
      if (out_vld && !out_busy) begin
         seq = int'(out_data[15:0]);
         out_busy = 1'b1;
         out_idx = 0;
         out_seq = -1;
         if (seq >= num_pkts || !pending[seq]) begin
            log_mismatch($sformatf("packet with unknown sequence number %0d", seq));
         end else begin
            out_seq = seq;
            // Handshake edge was five samples back
            pred = pick_after(ready_hist[(cyc + 3) % 8], last_served);
            checks++;
            if (pred != buf_of[seq])
               log_mismatch($sformatf("seq %0d came from buffer %0d, expected buffer %0d",
                                      seq, buf_of[seq], pred));
            last_served = buf_of[seq];
            ready_m[buf_of[seq]] = 1'b0;
         end
      end else if (!out_vld && out_busy) begin
         log_mismatch($sformatf("gap in out_vld at word %0d of seq %0d", out_idx, out_seq));
         out_busy = 1'b0;
      end
      if (out_vld && out_seq >= 0) begin
         checks++;
         if (out_idx >= fwd_pkg::max_words || out_data !== sent[out_seq][out_idx])
            log_mismatch($sformatf("seq %0d word %0d is %h", out_seq, out_idx, out_data));
         if (out_last !== (out_idx == sent_len[out_seq] - 1))
            log_mismatch($sformatf("out_last=%0b at word %0d of %0d", out_last, out_idx,
                                   sent_len[out_seq]));
      end
      if (out_vld)
         out_idx++;
      if (out_vld && out_last) begin
         out_busy = 1'b0;
         if (out_seq >= 0) begin
            pending[out_seq] = 1'b0;
            n_pending--;
            rel1_v = 1'b1;
            rel1_buf = buf_of[out_seq];
         end
      end
      ready_hist[cyc % 8] = ready_m;
   endtask

   task automatic drive_step();
      if (will_take) begin
         if (in_last) begin
            active = 1'b0;
            gap = gaps_on ? int'(rand_bits(3)) : 0;
         end else begin
            wcur++;
         end
      end
      if (!active && gap > 0) begin
         gap--;
      end else if (!active && next_seq < phase_end) begin
         cur = next_seq;
         next_seq++;
         sent_len[cur] = 1 + int'(rand_bits(4));
         sent[cur][0] = (rand_bits(16) << 16) | 32'(cur);
         for (int i = 1; i < sent_len[cur]; i++)
            sent[cur][i] = rand_bits(32);
         pending[cur] = 1'b1;
         n_pending++;
         active = 1'b1;
         wcur = 0;
      end
      in_vld = active;
      in_data = active ? sent[cur][wcur] : '0;
      in_last = active && (wcur == sent_len[cur] - 1);
      // in_rdy is stable here and holds through the next rising edge
      will_take = in_vld && in_rdy;
      take_last = will_take && in_last;
      take_mid = will_take && !in_last;
      // Lowest empty buffer gets a new packet
      if (will_take && wcur == 0) begin
         for (int i = nb - 1; i >= 0; i--) begin
            if (!used[i])
               take_buf = i;
         end
         used[take_buf] = 1'b1;
         buf_of[cur] = take_buf;
      end
   endtask

   task automatic tick();
      @(negedge clk);
      monitor_step();
      drive_step();
   endtask

   task automatic run_phase(input int last_seq, input bit with_gaps);
      gaps_on = with_gaps;
      phase_end = last_seq;
      while (next_seq < phase_end || active || n_pending > 0)
         tick();
      repeat (3) tick();
   endtask

   initial begin
      int e0;
      bit rdy_up;
      rst = 1'b1;
      in_data = '0;
      in_vld = 1'b0;
      in_last = 1'b0;
      last_served = nb - 1;
      out_seq = -1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Idle after reset
      e0 = errors;
      rdy_up = 1'b0;
      for (int i = 0; i < 8; i++) begin
         tick();
         if (i < 2 && in_rdy)
            rdy_up = 1'b1;
         if (out_vld)
            log_mismatch("out_vld high while idle");
      end
      if (!rdy_up) begin
         $display("in_rdy did not rise within 2 cycles after reset");
         errors++;
      end
      $display("test reset_idle: %0d errors", errors - e0);
      rdy_chk = 1'b1;

      e0 = errors;
      run_phase(num_pkts / 2, 1'b1);
      $display("test random_gaps: %0d errors", errors - e0);

      // No gaps so the buffers fill up
      e0 = errors;
      max_held = 0;
      run_phase(num_pkts, 1'b0);
      if (max_held < 2) begin
         $display("Back-to-back input never held more than one packet");
         errors++;
      end
      $display("test back_to_back: %0d errors, at most %0d packets held", errors - e0, max_held);

      if (n_pending != 0 || held != 0) begin
         $display("%0d packets were never forwarded", n_pending);
         errors++;
      end
      $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
               uut.u_arb.u_sva.fail_cnt);
      if (errors == 0 && uut.u_arb.u_sva.fail_cnt == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule
